//--- filelist.f
+incdir+design
design/sdramPkg.sv
design/hostPkg.sv
design/bufferCreditIf.sv
design/wordFifo.sv
design/sdramInit.sv
design/sdramSequencer.sv
design/sdramCtrlTop.sv
sim/sdramModel.sv
sim/tbSdramCtrl.sv

//--- run.sh
#!/bin/sh
# Build and run with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tbSdramCtrl \
    -o simv > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    ; grep -q "^Done: no errors$" sim.log && echo "PASS" \
    || { echo "FAIL"; exit 1; }

//--- sim/tbSdramCtrl.sv
`timescale 1ns/1ps
`include "sdramCtrl_params.svh"

module tbSdramCtrl
    import sdramPkg::*;
    import hostPkg::*;
();
    typedef struct packed {
        dir_t   dir;
        block_t blk;
        len_t   len;
        word_t  seed;
    } entry_t;

    localparam int NumEntries = 8;

    logic clk, arstN;
    logic cmdValid, cmdReady, blockDone;
    dir_t cmdDir;
    block_t cmdBlock;
    len_t cmdLen;
    logic writeValid, writeCredit;
    word_t writeData;
    logic readValid, readLast, readReady;
    word_t readData;
    logic ramCke, ramRasN, ramCasN, ramWeN, ramDqOutEn;
    bank_t ramBa;
    row_t ramA;
    logic [1:0] ramDqm;
    word_t ramDqOut, ramDqIn;
    logic initSeen;
    int modelErr;

    entry_t tbl [NumEntries];
    word_t refMem [int unsigned];
    readEntry_t rdQ [$];
    int errors, credits, doneCnt;
    logic aborted, prevStall;
    word_t prevData;

    sdramCtrlTop uut (
        .clk(clk), .arstN(arstN),
        .cmdValid(cmdValid), .cmdDir(cmdDir), .cmdBlock(cmdBlock), .cmdLen(cmdLen),
        .cmdReady(cmdReady), .blockDone(blockDone),
        .writeValid(writeValid), .writeData(writeData), .writeCredit(writeCredit),
        .readValid(readValid), .readData(readData), .readLast(readLast),
        .readReady(readReady),
        .ramCke(ramCke), .ramBa(ramBa), .ramA(ramA), .ramRasN(ramRasN),
        .ramCasN(ramCasN), .ramWeN(ramWeN), .ramDqm(ramDqm),
        .ramDqOut(ramDqOut), .ramDqOutEn(ramDqOutEn), .ramDqIn(ramDqIn)
    );

    sdramModel model (
        .clk(clk), .arstN(arstN), .cke(ramCke), .ba(ramBa), .a(ramA),
        .rasN(ramRasN), .casN(ramCasN), .weN(ramWeN), .dqm(ramDqm),
        .dqOut(ramDqOut), .dqOutEn(ramDqOutEn), .dqIn(ramDqIn),
        .initSeen(initSeen), .errCount(modelErr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic checkLast(input readEntry_t got, input readEntry_t exp);
        if (got.last !== exp.last) begin
            $display("ERR %0t readLast got %b expected %b", $time, got.last, exp.last);
            errors++;
        end
    endtask

    // Advance one clock and sample the host side where it is stable
    task automatic tick();
        @(posedge clk);
        #5;
        writeValid = 1'b0;
        credits += writeCredit;
        doneCnt += blockDone;
        if (credits > `FIFO_DEPTH) begin
            $display("More write credits returned than buffer slots at %0t", $time);
            errors++;
        end
        if (cmdReady && !initSeen) begin
            $display("cmdReady high before power-up finished at %0t", $time);
            errors++;
        end
        // A stalled word must still be there and unchanged
        if (prevStall) begin
            if (!readValid) begin
                $display("readValid dropped before the word was taken at %0t", $time);
                errors++;
            end else begin
                checkWord("readData", readData, prevData);
            end
        end
        readReady = ($urandom % 3) != 0;
        if (readValid && readReady) rdQ.push_back('{data: readData, last: readLast});
        prevStall = readValid && !readReady;
        prevData  = readData;
    endtask

    task automatic sendCommand(input entry_t e);
        int n;
        n = 0;
        while (!cmdReady && n < 3000) begin
            tick();
            n++;
        end
        if (!cmdReady) begin
            $display("Timeout waiting for cmdReady");
            errors++;
            aborted = 1'b1;
        end else begin
            cmdValid = 1'b1;
            cmdDir   = e.dir;
            cmdBlock = e.blk;
            cmdLen   = e.len;
            tick();
            cmdValid = 1'b0;
        end
    endtask

    task automatic runEntry(input entry_t e);
        int n;
        int pushed;
        int startDone;
        readEntry_t exp;
        n = 0;
        pushed = 0;
        startDone = doneCnt;
        rdQ.delete();
        sendCommand(e);
        if (aborted) return;
        // Host side of the transfer until blockDone and all data
        while (n < 2000 && (doneCnt == startDone ||
               (e.dir == DirRead && rdQ.size() < int'(e.len)))) begin
            if (e.dir == DirWrite && pushed < int'(e.len) && credits > 0 &&
                ($urandom % 3) == 0) begin
                writeValid = 1'b1;
                writeData  = word_t'($urandom) ^ e.seed;
                refMem[{e.blk, 4'(pushed)}] = writeData;
                credits--;
                pushed++;
            end
            tick();
            n++;
        end
        if (n >= 2000) begin
            $display("Timeout waiting for blockDone or read data");
            errors++;
            aborted = 1'b1;
            return;
        end
        if (doneCnt != startDone + 1) begin
            $display("blockDone pulsed %0d times for one command", doneCnt - startDone);
            errors++;
        end
        if (e.dir == DirRead) begin
            if (rdQ.size() != int'(e.len)) begin
                $display("Read returned %0d words instead of %0d", rdQ.size(), e.len);
                errors++;
            end
            for (int i = 0; i < rdQ.size() && i < int'(e.len); i++) begin
                exp.data = refMem[{e.blk, 4'(i)}];
                exp.last = (i == int'(e.len) - 1);
                checkWord("readData", rdQ[i].data, exp.data);
                checkLast(rdQ[i], exp);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h44bb_e630));
        arstN = 1'b0;
        cmdValid = 1'b0;
        cmdDir = DirRead;
        cmdBlock = '0;
        cmdLen = '0;
        writeValid = 1'b0;
        writeData = '0;
        readReady = 1'b0;
        errors = 0;
        credits = `FIFO_DEPTH;
        doneCnt = 0;
        aborted = 1'b0;
        prevStall = 1'b0;
        prevData = '0;
        // Columns are direction, block, length and data seed
        tbl[0] = '{DirWrite, 21'd3, 5'd5, 16'h1234};
        tbl[1] = '{DirRead, 21'd3, 5'd5, 16'h0000};
        tbl[2] = '{DirWrite, 21'd70000, 5'd16, 16'hbeef};
        tbl[3] = '{DirRead, 21'd70000, 5'd16, 16'h0000};
        tbl[4] = '{DirWrite, 21'd5, 5'd1, 16'h5a5a};
        tbl[5] = '{DirRead, 21'd5, 5'd1, 16'h0000};
        tbl[6] = '{DirRead, 21'd70000, 5'd8, 16'h0000};
        tbl[7] = '{DirRead, 21'd3, 5'd5, 16'h0000};
        repeat (8) @(posedge clk);
        #5;
        arstN = 1'b1;
        for (int i = 0; i < NumEntries && !aborted; i++) runEntry(tbl[i]);
        // Let refresh run a while with nothing pending
        repeat (200) tick();
        if (readValid) begin
            $display("Unexpected word left in the read buffer");
            errors++;
        end
        // One blockDone per command over the whole run
        if (doneCnt != NumEntries) begin
            $display("blockDone pulsed %0d times for %0d commands", doneCnt, NumEntries);
            errors++;
        end
        $display("Errors: testbench %0d, model %0d", errors, modelErr);
        if (errors == 0 && modelErr == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end
endmodule

//--- sim/sdramModel.sv
`timescale 1ns/1ps
`include "sdramCtrl_params.svh"

module sdramModel
    import sdramPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  logic       cke,
    input  bank_t      ba,
    input  row_t       a,
    input  logic       rasN,
    input  logic       casN,
    input  logic       weN,
    input  logic [1:0] dqm,
    input  word_t      dqOut,
    input  logic       dqOutEn,
    output word_t      dqIn,
    output logic       initSeen,
    output int         errCount
);
    localparam int Rcd      = clocks(`T_RCD_NS);
    localparam int Rp       = clocks(`T_RP_NS);
    localparam int RefLimit = clocks(`T_REFI_NS) + 30;

    word_t    mem [int unsigned];
    word_t    rdData [`CAS_LATENCY];
    longint   cyc;
    longint   actCyc;
    longint   preCyc;
    longint   refCyc;
    int       initStep;
    int       errNow;
    logic     rowOpen;
    logic     overdue;
    row_t     openRow;
    sdramOp_t op;

    function automatic word_t readMem(input int unsigned key);
        return mem.exists(key) ? mem[key] : 16'h0000;
    endfunction

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cyc      = 0;
            actCyc   = 0;
            preCyc   = 0;
            refCyc   = 0;
            initStep = 0;
            errNow   = 0;
            rowOpen  = 1'b0;
            overdue  = 1'b0;
            openRow  = '0;
            initSeen <= 1'b0;
            errCount <= 0;
            dqIn     <= '0;
            for (int i = 0; i < `CAS_LATENCY; i++) rdData[i] = '0;
        end else begin
            cyc    = cyc + 1;
            errNow = 0;
            op     = sdramOp_t'({rasN, casN, weN});
            // Read data walks toward the pins over CAS latency 3
            dqIn <= rdData[`CAS_LATENCY - 2];
            for (int i = `CAS_LATENCY - 1; i > 0; i--) rdData[i] = rdData[i - 1];
            rdData[0] = 'x;
            // ==============================
            // Power-up order
            // ==============================
            if (initStep < 5) begin
                if (initStep == 0 && cke) initStep = 1;
                if (op != Nop) begin
                    if (initStep == 1 && op == PrechargeAll && a[10]) begin
                        initStep = 2;
                        preCyc   = cyc;
                    end else if ((initStep == 2 || initStep == 3) && op == AutoRefresh) begin
                        initStep = initStep + 1;
                        refCyc   = cyc;
                    end else if (initStep == 4 && op == SetMode && a[6:4] == 3'd3 &&
                                 a[3] == 1'b0 && a[2:0] == 3'd0) begin
                        initStep = 5;
                        initSeen <= 1'b1;
                    end else begin
                        $display("Model: command %s out of power-up order at step %0d",
                                 op.name(), initStep);
                        errNow++;
                    end
                end
            end else begin
                case (op)
                    BankActivate: begin
                        if (cyc - preCyc < Rp) begin
                            $display("Model: tRP violated before activate at %0t", $time);
                            errNow++;
                        end
                        rowOpen = 1'b1;
                        openRow = a;
                        actCyc  = cyc;
                    end
                    Read, Write: begin
                        if (!rowOpen || cyc - actCyc < Rcd) begin
                            $display("Model: access without open row or tRCD at %0t", $time);
                            errNow++;
                        end
                        if (op == Write) mem[{ba, openRow, a[9:0]}] = dqOut;
                        else rdData[0] = readMem({ba, openRow, a[9:0]});
                    end
                    PrechargeAll: begin
                        rowOpen = 1'b0;
                        preCyc  = cyc;
                    end
                    AutoRefresh: begin
                        if (rowOpen || cyc - preCyc < Rp) begin
                            $display("Model: refresh with open row or tRP at %0t", $time);
                            errNow++;
                        end
                        refCyc  = cyc;
                        overdue = 1'b0;
                    end
                    default: ;
                endcase
                // Controller drives DQ only together with a WRITE
                if (op != Write && dqOutEn) begin
                    $display("Model: data driven outside a write at %0t", $time);
                    errNow++;
                end
                // Unmasked data on every access
                if ((op == Write && !dqOutEn) ||
                    ((op == Read || op == Write) && dqm != 2'b00)) begin
                    $display("Model: %s data not driven or masked at %0t", op.name(), $time);
                    errNow++;
                end
                // Refresh must keep coming
                if (!overdue && cyc - refCyc > RefLimit) begin
                    $display("Model: refresh overdue at %0t", $time);
                    errNow++;
                    overdue = 1'b1;
                end
            end
            errCount <= errCount + errNow;
        end
    end
endmodule

//--- design/sdramCtrlTop.sv
`timescale 1ns/1ps

module sdramCtrlTop
    import sdramPkg::*;
    import hostPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    // Command port
    input  logic       cmdValid,
    input  dir_t       cmdDir,
    input  block_t     cmdBlock,
    input  len_t       cmdLen,
    output logic       cmdReady,
    output logic       blockDone,
    // Write port, credit based
    input  logic       writeValid,
    input  word_t      writeData,
    output logic       writeCredit,
    // Read port, valid/ready
    output logic       readValid,
    output word_t      readData,
    output logic       readLast,
    input  logic       readReady,
    // SDRAM pins, chip select tied off on the board
    output logic       ramCke,
    output bank_t      ramBa,
    output row_t       ramA,
    output logic       ramRasN,
    output logic       ramCasN,
    output logic       ramWeN,
    output logic [1:0] ramDqm,
    // DQ split, the tristate lives on the board
    output word_t      ramDqOut,
    output logic       ramDqOutEn,
    input  word_t      ramDqIn
);
    sdramPins_t initPins;
    sdramPins_t pins;
    logic       initDone;

    bufferCreditIf #(.T(word_t))      wrBuf ();
    bufferCreditIf #(.T(readEntry_t)) rdBuf ();

    // ==============================
    // Host side of the buffers
    // ==============================
    assign wrBuf.push     = writeValid;
    assign wrBuf.pushData = writeData;
    assign writeCredit    = wrBuf.credit;

    assign readValid      = rdBuf.popValid;
    assign readData       = rdBuf.popData.data;
    assign readLast       = rdBuf.popData.last;
    assign rdBuf.pop      = rdBuf.popValid && readReady;

    wordFifo #(.T(word_t)) wrFifo (
        .clk   (clk),
        .arstN (arstN),
        .port  (wrBuf.buffer)
    );

    wordFifo #(.T(readEntry_t)) rdFifo (
        .clk   (clk),
        .arstN (arstN),
        .port  (rdBuf.buffer)
    );

    sdramInit init (
        .clk      (clk),
        .arstN    (arstN),
        .pins     (initPins),
        .initDone (initDone)
    );

    sdramSequencer seq (
        .clk       (clk),
        .arstN     (arstN),
        .cmdValid  (cmdValid),
        .cmdDir    (cmdDir),
        .cmdBlock  (cmdBlock),
        .cmdLen    (cmdLen),
        .cmdReady  (cmdReady),
        .blockDone (blockDone),
        .initPins  (initPins),
        .initDone  (initDone),
        .wrPort    (wrBuf.consumer),
        .rdPort    (rdBuf.producer),
        .pins      (pins),
        .dqIn      (ramDqIn)
    );

    // Pin bundle onto device ports
    assign ramCke                      = pins.cke;
    assign ramBa                       = pins.bank;
    assign ramA                        = pins.addr;
    assign {ramRasN, ramCasN, ramWeN}  = pins.op;
    assign ramDqm                      = pins.dqm;
    assign ramDqOut                    = pins.dqOut;
    assign ramDqOutEn                  = pins.dqOutEn;
endmodule

//--- design/sdramSequencer.sv
`timescale 1ns/1ps
`include "sdramCtrl_params.svh"

module sdramSequencer
    import sdramPkg::*;
    import hostPkg::*;
(
    input  logic            clk,
    input  logic            arstN,
    // Host command
    input  logic            cmdValid,
    input  dir_t            cmdDir,
    input  block_t          cmdBlock,
    input  len_t            cmdLen,
    output logic            cmdReady,
    output logic            blockDone,
    // From the power-up sequencer
    input  sdramPins_t      initPins,
    input  logic            initDone,
    // Buffers
    bufferCreditIf.consumer wrPort,
    bufferCreditIf.producer rdPort,
    // Device side
    output sdramPins_t      pins,
    input  word_t           dqIn
);
    localparam int Cl        = `CAS_LATENCY;
    localparam int Depth     = `FIFO_DEPTH;
    localparam int CreditW   = $clog2(Depth + 1);
    localparam int BlockLog2 = $clog2(`BLOCK_SIZE);
    localparam int WaitW     = 8;
    localparam int Rcd       = clocks(`T_RCD_NS);
    localparam int Rp        = clocks(`T_RP_NS);
    localparam int Rfc       = clocks(`T_RFC_NS);
    // Row must stay open for tRAS, and the next activate needs tRC
    localparam int RowMin  = (clocks(`T_RC_NS) - Rp > clocks(`T_RAS_NS)) ?
                             clocks(`T_RC_NS) - Rp : clocks(`T_RAS_NS);
    localparam int Recover = (clocks(`T_WR_NS) > RowMin) ? clocks(`T_WR_NS) : RowMin;
    localparam int RefiReload = clocks(`T_REFI_NS) - 1;
    localparam int RefW       = $clog2(RefiReload + 1);

    typedef enum logic [2:0] {
        Idle,
        Activate,
        Transfer,
        Drain,
        Precharge,
        Refresh
    } seqState_t;

    seqState_t          state;
    logic [WaitW-1:0]   waitCnt;
    logic [RefW-1:0]    refCount;
    logic               refPending;
    dir_t               dir;
    bank_t              bank;
    row_t               row;
    col_t               col;
    len_t               remaining;
    sdramPins_t         seqPins;
    // One bit per cycle since a READ, oldest at the top
    logic [Cl:0]        rdPipe;
    logic [Cl:0]        lastPipe;
    logic [CreditW-1:0] rdCredits;
    logic [3:0]         sinceActivate;
    logic               active;
    logic               writeIssue;
    logic               readIssue;

    // Pins belong to the initializer until it is done
    assign pins = initDone ? seqPins : initPins;

    assign cmdReady = initDone && (state == Idle) && (waitCnt == '0) && !refPending;

    // A word slot, refresh takes it at the boundary
    assign active     = (state == Transfer) && (waitCnt == '0) && !refPending &&
                        (remaining != '0);
    assign writeIssue = active && (dir == DirWrite) && wrPort.popValid;
    assign readIssue  = active && (dir == DirRead) && (rdCredits != '0);
    assign wrPort.pop = writeIssue;

    // Read data lands straight in the buffer
    assign rdPort.push     = rdPipe[Cl];
    assign rdPort.pushData = readEntry_t'{data: dqIn, last: lastPipe[Cl]};

    // ==============================
    // Transfer FSM and refresh timer
    // ==============================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state      <= Idle;
            waitCnt    <= '0;
            refCount   <= RefW'(RefiReload);
            refPending <= 1'b0;
            blockDone  <= 1'b0;
            dir        <= DirRead;
            bank       <= '0;
            row        <= '0;
            col        <= '0;
            remaining  <= '0;
            seqPins    <= '{cke: 1'b0, op: Nop, dqm: 2'b11, default: '0};
        end else begin
            seqPins.cke     <= 1'b1;
            seqPins.op      <= Nop;
            seqPins.dqm     <= 2'b00;
            seqPins.dqOutEn <= 1'b0;
            blockDone       <= 1'b0;
            if (waitCnt != '0) begin
                waitCnt <= waitCnt - 1'b1;
            end else begin
                case (state)
                    Idle: begin
                        if (refPending) begin
                            state <= Refresh;
                        end else if (cmdValid && cmdReady) begin
                            dir              <= cmdDir;
                            {bank, row, col} <= {cmdBlock, BlockLog2'(0)};
                            remaining        <= cmdLen;
                            state            <= Activate;
                        end
                    end
                    Activate: begin
                        seqPins.op   <= BankActivate;
                        seqPins.bank <= bank;
                        seqPins.addr <= row;
                        waitCnt      <= WaitW'(Rcd - 1);
                        state        <= Transfer;
                    end
                    Transfer: begin
                        // Single-word commands, A10 low so the row stays open
                        if (writeIssue || readIssue) begin
                            seqPins.op      <= writeIssue ? Write : Read;
                            seqPins.bank    <= bank;
                            seqPins.addr    <= {3'b000, col};
                            seqPins.dqOut   <= wrPort.popData;
                            seqPins.dqOutEn <= writeIssue;
                            col             <= col + 1'b1;
                            remaining       <= remaining - 1'b1;
                        end else if (remaining == '0 || refPending) begin
                            waitCnt <= WaitW'(Recover - 1);
                            state   <= Drain;
                        end
                    end
                    // Reads still inside CAS latency must come back first
                    Drain: begin
                        if (rdPipe == '0) state <= Precharge;
                    end
                    Precharge: begin
                        seqPins.op   <= PrechargeAll;
                        seqPins.addr <= PrechargeAllAddr;
                        waitCnt      <= WaitW'(Rp - 1);
                        blockDone    <= (remaining == '0);
                        state        <= refPending ? Refresh : Idle;
                    end
                    default: begin
                        // Rows are closed here, resume by reopening the row
                        seqPins.op <= AutoRefresh;
                        waitCnt    <= WaitW'(Rfc - 1);
                        refPending <= 1'b0;
                        state      <= (remaining != '0) ? Activate : Idle;
                    end
                endcase
            end
            // Timer only runs once the device is up
            if (!initDone) begin
                refCount <= RefW'(RefiReload);
            end else if (refCount == '0) begin
                refCount   <= RefW'(RefiReload);
                refPending <= 1'b1;
            end else begin
                refCount <= refCount - 1'b1;
            end
        end
    end

    // ==============================
    // Reads in flight and read credits
    // ==============================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdPipe        <= '0;
            lastPipe      <= '0;
            rdCredits     <= CreditW'(Depth);
            sinceActivate <= '0;
        end else begin
            rdPipe    <= {rdPipe[Cl-1:0], readIssue};
            lastPipe  <= {lastPipe[Cl-1:0], readIssue && (remaining == len_t'(1))};
            // A read holds its credit from issue until the host pops it
            rdCredits <= rdCredits - CreditW'(readIssue) + CreditW'(rdPort.credit);
            // Clocks since BankActivate reached the pins, saturating
            if (seqPins.op == BankActivate) begin
                sinceActivate <= 4'd1;
            end else if (sinceActivate != 4'hf) begin
                sinceActivate <= sinceActivate + 1'b1;
            end
        end
    end

    // tRCD between BankActivate and the first access
    assert property (@(posedge clk) disable iff (!arstN)
        (seqPins.op inside {Read, Write}) |-> (sinceActivate >= Rcd))
        else $error("sdramSequencer: tRCD violated");

    // Returned credits never outnumber the read buffer slots
    assert property (@(posedge clk) disable iff (!arstN)
        rdCredits <= CreditW'(Depth))
        else $error("sdramSequencer: read credit overflow");
endmodule

//--- design/sdramInit.sv
`timescale 1ns/1ps
`include "sdramCtrl_params.svh"

module sdramInit
    import sdramPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    output sdramPins_t pins,
    output logic       initDone
);
    localparam int PowerUp = clocks(`T_INIT_NS);
    // Idle clocks between CKE rising and the first command
    localparam int CkeHold = 10;
    localparam int DelayW  = $clog2(PowerUp + 1);
    // Burst write, normal mode, CAS latency, sequential, burst length 1
    localparam row_t ModeWord = {3'b000, 1'b0, 2'b00, 3'(`CAS_LATENCY), 1'b0, 3'b000};

    typedef enum logic [2:0] {
        InitPowerUp,
        InitPrecharge,
        InitRefresh1,
        InitRefresh2,
        InitMode,
        InitReady
    } initState_t;

    initState_t        state;
    logic [DelayW-1:0] delay;

    // ==============================
    // Power-up sequence
    // ==============================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= InitPowerUp;
            delay    <= DelayW'(PowerUp);
            initDone <= 1'b0;
            pins     <= '{cke: 1'b0, op: Nop, dqm: 2'b11, default: '0};
        end else begin
            pins.op <= Nop;
            // Every step waits out the previous one first
            if (delay != '0) begin
                delay <= delay - 1'b1;
            end else begin
                case (state)
                    InitPowerUp: begin
                        pins.cke <= 1'b1;
                        delay    <= DelayW'(CkeHold);
                        state    <= InitPrecharge;
                    end
                    InitPrecharge: begin
                        pins.op   <= PrechargeAll;
                        pins.addr <= PrechargeAllAddr;
                        delay     <= DelayW'(clocks(`T_RP_NS));
                        state     <= InitRefresh1;
                    end
                    // Two refreshes, each given its full tRFC
                    InitRefresh1, InitRefresh2: begin
                        pins.op <= AutoRefresh;
                        delay   <= DelayW'(clocks(`T_RFC_NS));
                        state   <= (state == InitRefresh1) ? InitRefresh2 : InitMode;
                    end
                    InitMode: begin
                        pins.op   <= SetMode;
                        pins.bank <= '0;
                        pins.addr <= ModeWord;
                        // tMRD before the sequencer takes over
                        delay     <= DelayW'(`MRD_CYCLES);
                        state     <= InitReady;
                    end
                    default: begin
                        initDone <= 1'b1;
                    end
                endcase
            end
        end
    end

    // Commands never come back to back during power-up
    assert property (@(posedge clk) disable iff (!arstN)
        (pins.op != Nop) |=> (pins.op == Nop))
        else $error("sdramInit: commands closer than 2 cycles");
endmodule

//--- design/wordFifo.sv
`timescale 1ns/1ps
`include "sdramCtrl_params.svh"

module wordFifo #(
    parameter type T = logic [15:0]
) (
    input logic           clk,
    input logic           arstN,
    bufferCreditIf.buffer port
);
    localparam int Depth = `FIFO_DEPTH;
    localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;

    T                mem [Depth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [PtrW:0]   count;

    // Wrap at the last slot, depth need not be a power of two
    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Head of queue is always on the read side
    assign port.popValid = (count != '0);
    assign port.popData  = mem[rdPtr];
    // Each freed slot goes straight back as a credit
    assign port.credit   = port.pop;

    always_ff @(posedge clk) begin
        if (port.push) mem[wrPtr] <= port.pushData;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (port.push) wrPtr <= nextPtr(wrPtr);
            if (port.pop) rdPtr <= nextPtr(rdPtr);
            count <= count + port.push - port.pop;
        end
    end

    // Producer keeps to its credits
    assert property (@(posedge clk) disable iff (!arstN)
        port.push |-> (count != (PtrW + 1)'(Depth)))
        else $error("wordFifo: push while full");

    // Consumer keeps to popValid
    assert property (@(posedge clk) disable iff (!arstN)
        port.pop |-> (count != '0))
        else $error("wordFifo: pop while empty");
endmodule

//--- design/bufferCreditIf.sv
`timescale 1ns/1ps

// Buffer link under credit flow control
interface bufferCreditIf #(
    parameter type T = logic [15:0]
);
    // Filled by the producer
    logic push;
    T     pushData;
    // One pulse per pop, back to the producer
    logic credit;
    // Drained by the consumer
    logic pop;
    T     popData;
    logic popValid;

    modport producer (output push, output pushData, input credit);

    modport buffer (
        input  push,
        input  pushData,
        output credit,
        input  pop,
        output popData,
        output popValid
    );

    modport consumer (output pop, input popData, input popValid);
endinterface

//--- design/hostPkg.sv
`include "sdramCtrl_params.svh"

package hostPkg;
    import sdramPkg::*;

    typedef enum logic {DirRead = 1'b0, DirWrite = 1'b1} dir_t;

    // Full word address is bank, row and column
    localparam int AddrWidth  = $bits(bank_t) + $bits(row_t) + $bits(col_t);
    localparam int BlockWidth = AddrWidth - $clog2(`BLOCK_SIZE);

    typedef logic [BlockWidth-1:0] block_t;

    // Up to a full block, so one bit wider than the offset
    typedef logic [$clog2(`BLOCK_SIZE):0] len_t;

    // Read buffer slot
    typedef struct packed {
        word_t data;
        logic  last;
    } readEntry_t;
endpackage

//--- design/sdramPkg.sv
`include "sdramCtrl_params.svh"

package sdramPkg;
    // RAS#, CAS#, WE# as they appear on the pins
    typedef enum logic [2:0] {
        SetMode      = 3'b000,
        AutoRefresh  = 3'b001,
        PrechargeAll = 3'b010,
        BankActivate = 3'b011,
        Write        = 3'b100,
        Read         = 3'b101,
        Nop          = 3'b111
    } sdramOp_t;

    // Address fields of a 4 bank, 8192 row, 1024 column part
    typedef logic [1:0]  bank_t;
    typedef logic [12:0] row_t;
    typedef logic [9:0]  col_t;
    typedef logic [15:0] word_t;

    // A10 high selects every bank
    localparam row_t PrechargeAllAddr = 13'h0400;

    // Everything the controller drives toward the device in one cycle
    typedef struct packed {
        logic       cke;
        sdramOp_t   op;
        bank_t      bank;
        row_t       addr;
        logic [1:0] dqm;
        word_t      dqOut;
        logic       dqOutEn;
    } sdramPins_t;

    // Nanoseconds to whole clocks, rounded up
    function automatic int clocks(input longint unsigned ns);
        return int'((ns * `CLK_FREQ_HZ + 64'd999_999_999) / 64'd1_000_000_000);
    endfunction
endpackage

//--- design/sdramCtrl_params.svh
`ifndef SDRAMCTRL_PARAMS_SVH
`define SDRAMCTRL_PARAMS_SVH

// System clock
`define CLK_FREQ_HZ 10_000_000

// Device timings in ns
`define T_INIT_NS   200_000
`define T_REFI_NS   7_812
`define T_RC_NS     68
`define T_RFC_NS    72
`define T_RAS_NS    45
`define T_RCD_NS    18
`define T_RP_NS     18
`define T_WR_NS     15

// Device timings in clocks
`define CAS_LATENCY 3
`define MRD_CYCLES  2

// Host transfer geometry
`define BLOCK_SIZE  16
`define FIFO_DEPTH  4

`endif
